// ==== c16_loader.f ====
+incdir+design
design/c16_loader_pkg.sv
design/load_decoder.sv
design/slot_timer.sv
design/ram_write_sched.sv
design/zp_shadow.sv
design/c16_loader_top.sv
test/c16_loader_props.sv
test/c16_loader_tb.sv

// ==== design/c16_loader_macros.svh ====
// c16 download path constants
// memory bases, download indices, zero-page pointer addresses
// and the width of the access phase counter
`ifndef C16_LOADER_MACROS_SVH
`define C16_LOADER_MACROS_SVH

// ----------------------------------------
// ram placement of downloaded images
// ----------------------------------------
// system rom images land here
`define C16_ROM_MEM_START 25'h0010000
// tape images land here, above the rom area
`define C16_TAP_MEM_START 25'h0020000
// full rom image starts with the old drive rom, skip it
`define C16_ROM_SKIP 25'h0004000

// ----------------------------------------
// download index codes from the io controller
// ----------------------------------------
`define C16_IDX_ROM_FULL 8'h00
`define C16_IDX_PRG 8'h01
`define C16_IDX_ROM_KERNAL 8'h03
`define C16_IDX_TAP 8'h41

// basic end pointers, low byte here and high byte at the next address
`define C16_ZP_PTR0 16'h002d
`define C16_ZP_PTR1 16'h002f
`define C16_ZP_PTR2 16'h0031
`define C16_ZP_PTR3 16'h009d

// phase counter width, one full access period per wrap
`define C16_SLOT_BITS 4

`endif

// ==== design/c16_loader_pkg.sv ====
// c16 download path types
// vector widths, download kind and load event encoding shared by all stages
package c16_loader_pkg;

	// ----------------------------------------
	// plain vectors with a meaning
	// ----------------------------------------
	typedef logic [7:0] byte_t;
	// byte address into the shared ram
	typedef logic [24:0] ram_addr_t;
	// offset of a byte inside the running download
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] cpu_addr_t;
	// basic pointer held in the zero-page shadow
	typedef logic [15:0] zp_ptr_t;
	typedef logic [7:0] dl_index_t;

	// what kind of image is being downloaded
	typedef enum logic [1:0] {
		NONE,
		ROM,
		PRG,
		TAP
	} dl_kind_e;

	// action the write scheduler takes for one host byte
	typedef enum logic [2:0] {
		NOP,
		// prg header bytes carry the load address
		ADDR_LO,
		ADDR_HI,
		// plain byte, written at the running address
		DATA,
		// jump to base, then write the byte there
		SEEK_DATA
	} load_op_e;

	// one decoded host byte, valid for a single cycle
	typedef struct packed {
		load_op_e op;
		ram_addr_t base;
		byte_t data;
	} load_evt_t;

endpackage

// ==== design/c16_loader_top.sv ====
// c16 download path top level
// decoder, slot timer, ram write scheduler and zero-page shadow
`timescale 1ns/1ps

module c16_loader_top import c16_loader_pkg::*; (
	input  logic      clk28,
	input  logic      reset,
	// host download stream
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  logic      dl_wr_i,
	input  dl_addr_t  dl_addr_i,
	input  byte_t     dl_data_i,
	// computer ras strobe
	input  logic      ras_n_i,
	// cpu access to the shadow bytes
	input  cpu_addr_t cpu_addr_i,
	input  logic      cpu_wr_i,
	input  byte_t     cpu_data_i,
	// shared ram write port
	output logic      mem_wr_o,
	output ram_addr_t mem_addr_o,
	output byte_t     mem_data_o,
	output logic      cpu_wait_o,
	output logic      zp_hit_o,
	output byte_t     zp_data_o
);

	dl_kind_e  kind;
	load_evt_t evt;
	logic      io_start;
	logic      cpu_start;

	// ----------------------------------------
	// download stream to events
	// ----------------------------------------
	load_decoder u_load_decoder (
		.clk28       (clk28),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.kind_o      (kind),
		.evt_o       (evt),
		.cpu_wait_o  (cpu_wait_o)
	);

	slot_timer u_slot_timer (
		.clk28       (clk28),
		.reset       (reset),
		.ras_n_i     (ras_n_i),
		.io_start_o  (io_start),
		.cpu_start_o (cpu_start)
	);

	// writes land in the io half of each period
	ram_write_sched u_ram_write_sched (
		.clk28       (clk28),
		.reset       (reset),
		.evt_i       (evt),
		.io_start_i  (io_start),
		.cpu_start_i (cpu_start),
		.mem_wr_o    (mem_wr_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

	// end pointers come from the scheduler's running address
	zp_shadow u_zp_shadow (
		.clk28       (clk28),
		.reset       (reset),
		.kind_i      (kind),
		.dl_active_i (dl_active_i),
		.end_addr_i  (mem_addr_o),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wr_i    (cpu_wr_i),
		.cpu_data_i  (cpu_data_i),
		.zp_hit_o    (zp_hit_o),
		.zp_data_o   (zp_data_o)
	);

endmodule

// ==== design/load_decoder.sv ====
// download decoder
// classifies the download index and turns each host byte into a load event
`timescale 1ns/1ps
`include "c16_loader_macros.svh"

module load_decoder import c16_loader_pkg::*; (
	input  logic      clk28,
	input  logic      reset,
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  logic      dl_wr_i,
	input  dl_addr_t  dl_addr_i,
	input  byte_t     dl_data_i,
	output dl_kind_e  kind_o,
	output load_evt_t evt_o,
	output logic      cpu_wait_o
);

	load_op_e  op_d, op_q;
	ram_addr_t base_d, base_q;
	byte_t     data_q;

	// ----------------------------------------
	// kind of the running download
	// ----------------------------------------
	always_comb begin
		kind_o = NONE;
		if (dl_active_i) begin
			case (dl_index_i)
				`C16_IDX_ROM_FULL, `C16_IDX_ROM_KERNAL: kind_o = ROM;
				`C16_IDX_PRG: kind_o = PRG;
				`C16_IDX_TAP: kind_o = TAP;
				default: kind_o = NONE;
			endcase
		end
	end

	// cpu is held off while rom or program bytes go into ram
	assign cpu_wait_o = (kind_o == ROM) || (kind_o == PRG);

	// ----------------------------------------
	// byte classification
	// ----------------------------------------
	always_comb begin
		op_d = NOP;
		base_d = '0;
		if (dl_wr_i) begin
			case (kind_o)
				PRG: begin
					// two byte load address header, then payload
					if (dl_addr_i == 25'd0)
						op_d = ADDR_LO;
					else if (dl_addr_i == 25'd1)
						op_d = ADDR_HI;
					else
						op_d = DATA;
				end
				TAP: begin
					base_d = `C16_TAP_MEM_START;
					op_d = (dl_addr_i == 25'd0) ? SEEK_DATA : DATA;
				end
				ROM: begin
					base_d = `C16_ROM_MEM_START;
					if (dl_index_i == `C16_IDX_ROM_KERNAL)
						op_d = (dl_addr_i == 25'd0) ? SEEK_DATA : DATA;
					// full image, drop the leading drive rom part
					else if (dl_addr_i < `C16_ROM_SKIP)
						op_d = NOP;
					else if (dl_addr_i == `C16_ROM_SKIP)
						op_d = SEEK_DATA;
					else
						op_d = DATA;
				end
				default: op_d = NOP;
			endcase
		end
	end

	// event valid for the one cycle after the strobe
	always_ff @(posedge clk28) begin
		if (reset)
			op_q <= NOP;
		else
			op_q <= op_d;
	end

	always_ff @(posedge clk28) begin
		base_q <= base_d;
		data_q <= dl_data_i;
	end

	assign evt_o = '{op: op_q, base: base_q, data: data_q};

endmodule

// ==== design/ram_write_sched.sv ====
// ram write scheduler
// owns the ram byte address and issues one pending write per io half
`timescale 1ns/1ps

module ram_write_sched import c16_loader_pkg::*; (
	input  logic      clk28,
	input  logic      reset,
	input  load_evt_t evt_i,
	input  logic      io_start_i,
	input  logic      cpu_start_i,
	output logic      mem_wr_o,
	output ram_addr_t mem_addr_o,
	output byte_t     mem_data_o
);

	logic  pending_q;
	byte_t latch_q;
	logic  has_byte;

	// payload ops leave a byte waiting for the next io half
	assign has_byte = (evt_i.op == DATA) || (evt_i.op == SEEK_DATA);

	// ----------------------------------------
	// write strobe, pending flag and address
	// ----------------------------------------
	always_ff @(posedge clk28) begin
		if (reset) begin
			mem_wr_o <= 1'b0;
			pending_q <= 1'b0;
			mem_addr_o <= '0;
		end else begin
			// io half begins, hand the waiting byte to ram
			if (io_start_i) begin
				mem_wr_o <= pending_q;
				pending_q <= 1'b0;
			end

			// cpu half begins, close the write and step on
			if (cpu_start_i) begin
				mem_wr_o <= 1'b0;
				if (mem_wr_o)
					mem_addr_o <= mem_addr_o + 25'd1;
			end

			// host events win over the slot logic
			case (evt_i.op)
				ADDR_LO: mem_addr_o[7:0] <= evt_i.data;
				// high header byte also clears everything above it
				ADDR_HI: mem_addr_o[24:8] <= {9'd0, evt_i.data};
				SEEK_DATA: mem_addr_o <= evt_i.base;
				default: ;
			endcase
			if (has_byte)
				pending_q <= 1'b1;
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------
	always_ff @(posedge clk28) begin
		// a second byte in the same slot replaces the first
		if (has_byte)
			latch_q <= evt_i.data;
		if (io_start_i && pending_q)
			mem_data_o <= latch_q;
	end

endmodule

// ==== design/slot_timer.sv ====
// access slot timer
// keeps the phase counter in step with ras and marks the start of each half
`timescale 1ns/1ps
`include "c16_loader_macros.svh"

module slot_timer (
	input  logic clk28,
	input  logic reset,
	input  logic ras_n_i,
	output logic io_start_o,
	output logic cpu_start_o
);

	logic                      ras_n_q;
	logic [`C16_SLOT_BITS-1:0] phase_q;
	logic                      half_q;
	logic                      ras_fall;
	logic                      cpu_half;

	// ras just went low, restart the access period
	assign ras_fall = ras_n_q && !ras_n_i;

	always_ff @(posedge clk28) begin
		if (reset) begin
			ras_n_q <= 1'b1;
			phase_q <= '0;
			half_q <= 1'b0;
		end else begin
			ras_n_q <= ras_n_i;
			// free running between ras edges, wraps each period
			if (ras_fall)
				phase_q <= '0;
			else
				phase_q <= phase_q + 1'b1;
			half_q <= cpu_half;
		end
	end

	// upper half of the period belongs to the cpu
	assign cpu_half = phase_q[`C16_SLOT_BITS-1];

	// one cycle pulses on the half boundaries
	assign io_start_o = half_q && !cpu_half;
	assign cpu_start_o = !half_q && cpu_half;

endmodule

// ==== design/zp_shadow.sv ====
// zero-page pointer shadow
// holds the basic end pointers, loaded at the end of a program download
// and readable and writable by the cpu as eight overlay bytes
`timescale 1ns/1ps
`include "c16_loader_macros.svh"

module zp_shadow import c16_loader_pkg::*; (
	input  logic      clk28,
	input  logic      reset,
	input  dl_kind_e  kind_i,
	input  logic      dl_active_i,
	input  ram_addr_t end_addr_i,
	input  cpu_addr_t cpu_addr_i,
	input  logic      cpu_wr_i,
	input  byte_t     cpu_data_i,
	output logic      zp_hit_o,
	output byte_t     zp_data_o
);

	// low byte address of each pointer
	localparam cpu_addr_t PTR_ADDR [4] = '{
		`C16_ZP_PTR0,
		`C16_ZP_PTR1,
		`C16_ZP_PTR2,
		`C16_ZP_PTR3
	};

	zp_ptr_t ptr_q [4];
	logic    prg_dl;
	logic    prg_dl_q;
	logic    prg_end_q;
	logic    sel_lo [4];
	logic    sel_hi [4];

	// ----------------------------------------
	// end of program download
	// ----------------------------------------
	assign prg_dl = dl_active_i && (kind_i == PRG);

	always_ff @(posedge clk28) begin
		if (reset) begin
			prg_dl_q <= 1'b0;
			prg_end_q <= 1'b0;
		end else begin
			prg_dl_q <= prg_dl;
			// one cycle after the download level drops
			prg_end_q <= prg_dl_q && !prg_dl;
		end
	end

	// ----------------------------------------
	// cpu address decode and read overlay
	// ----------------------------------------
	always_comb begin
		zp_hit_o = 1'b0;
		// nothing of ours at this address, read as open bus
		zp_data_o = 8'hff;
		for (int i = 0; i < 4; i++) begin
			sel_lo[i] = (cpu_addr_i == PTR_ADDR[i]);
			sel_hi[i] = (cpu_addr_i == PTR_ADDR[i] + 16'd1);
			if (sel_lo[i]) begin
				zp_hit_o = 1'b1;
				zp_data_o = ptr_q[i][7:0];
			end
			if (sel_hi[i]) begin
				zp_hit_o = 1'b1;
				zp_data_o = ptr_q[i][15:8];
			end
		end
	end

	// ----------------------------------------
	// pointer registers
	// ----------------------------------------
	always_ff @(posedge clk28) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				ptr_q[i] <= '0;
		end else if (prg_end_q) begin
			// running address is one past the last byte, pointers go one further
			for (int i = 0; i < 4; i++)
				ptr_q[i] <= end_addr_i[15:0] + 16'd1;
		end else if (cpu_wr_i) begin
			for (int i = 0; i < 4; i++) begin
				if (sel_lo[i])
					ptr_q[i][7:0] <= cpu_data_i;
				if (sel_hi[i])
					ptr_q[i][15:8] <= cpu_data_i;
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module c16_loader_tb -f c16_loader.f -o c16_loader_sim || exit 1
out=$(./obj_dir/c16_loader_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "run ok" || { echo "run not ok"; exit 1; }

// ==== test/c16_loader_props.sv ====
// c16 download path assertions
// write strobe and cpu wait rules, bound into the loader top level
`timescale 1ns/1ps

module c16_loader_props (
	input logic clk28,
	input logic reset,
	input logic mem_wr_i,
	input logic cpu_start_i,
	input logic cpu_wait_i,
	input logic dl_active_i
);

	// no ram write comes out of reset
	wr_in_reset: assert property (@(posedge clk28) reset |=> !mem_wr_i)
		else $error("mem_wr_o high while reset was applied");

	// a write is only closed by the cpu half, never cut short inside the io half
	wr_at_cpu_start: assert property (
		@(posedge clk28) disable iff (reset) $fell(mem_wr_i) |-> $past(cpu_start_i))
		else $error("mem_wr_o dropped without a cpu_start");

	// wait level only exists inside a download
	wait_outside_dl: assert property (
		@(posedge clk28) disable iff (reset) !(cpu_wait_i && !dl_active_i))
		else $error("cpu_wait_o high with no download active");

endmodule

bind c16_loader_top c16_loader_props props (
	.clk28       (clk28),
	.reset       (reset),
	.mem_wr_i    (mem_wr_o),
	.cpu_start_i (cpu_start),
	.cpu_wait_i  (cpu_wait_o),
	.dl_active_i (dl_active_i)
);

// ==== test/c16_loader_tb.sv ====
// c16 download path testbench
// replays the command vectors against the loader top level, collects the
// ram writes and checks them, the cpu wait level and the zero-page overlay
`timescale 1ns/1ps

module c16_loader_tb import c16_loader_pkg::*; ();

	logic      clk28;
	logic      reset;
	logic      dl_active_i;
	dl_index_t dl_index_i;
	logic      dl_wr_i;
	dl_addr_t  dl_addr_i;
	byte_t     dl_data_i;
	logic      ras_n_i;
	cpu_addr_t cpu_addr_i;
	logic      cpu_wr_i;
	byte_t     cpu_data_i;
	logic      mem_wr_o;
	ram_addr_t mem_addr_o;
	byte_t     mem_data_o;
	logic      cpu_wait_o;
	logic      zp_hit_o;
	byte_t     zp_data_o;

	// parsed vector file, one entry per command
	logic [7:0]  cmd_q [$];
	logic [31:0] f0_q [$];
	logic [31:0] f1_q [$];
	logic [31:0] f2_q [$];
	string       name_q [$];
	int          n_vec = 0;

	// ram writes seen on the bus, oldest first
	ram_addr_t wr_addr_q [$];
	byte_t     wr_data_q [$];
	logic      wr_prev = 1'b0;

	string cur_test = "";
	logic  wait_exp = 1'b0;
	int    test_errs = 0;
	int    n_tests = 0;
	int    n_failed = 0;
	int    n_checks = 0;
	int    n_errors = 0;

	c16_loader_top dut (.*);

	initial begin
		clk28 = 1'b0;
		forever #2 clk28 = ~clk28;
	end

	// ----------------------------------------
	// ras strobe, one low cycle per 16
	// ----------------------------------------
	initial begin
		ras_n_i = 1'b1;
		forever begin
			repeat (15) tick();
			ras_n_i = 1'b0;
			tick();
			ras_n_i = 1'b1;
		end
	end

	// catch each rising edge of the write strobe mid-cycle
	always @(negedge clk28) begin
		if (mem_wr_o === 1'b1 && !wr_prev) begin
			wr_addr_q.push_back(mem_addr_o);
			wr_data_q.push_back(mem_data_o);
		end
		wr_prev = (mem_wr_o === 1'b1);
	end

	// budget of 64 cycles per command, plus room for reset
	initial begin
		wait (n_vec > 0);
		repeat (n_vec * 64 + 100) @(posedge clk28);
		$display("timeout: the vectors did not finish in the allowed cycles");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// inputs move 1 ns after the rising edge
	task automatic tick();
		@(posedge clk28);
		#1;
	endtask

	task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
		n_checks++;
		if (exp !== act) begin
			$display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, exp, act);
			n_errors++;
			test_errs++;
		end
	endtask

	// idle cycles, wait level checked in each
	task automatic idle_cycles(int n);
		repeat (n) begin
			tick();
			@(negedge clk28);
			check_value("cpu_wait", {31'd0, wait_exp}, {31'd0, cpu_wait_o});
		end
	endtask

	task automatic finish_test();
		// writes left over were never asked for
		if (wr_addr_q.size() != 0) begin
			$display("test %s: %0d ram writes that no vector expected, first at %h",
				cur_test, wr_addr_q.size(), wr_addr_q[0]);
			wr_addr_q.delete();
			wr_data_q.delete();
			n_errors++;
			test_errs++;
		end
		n_tests++;
		if (test_errs == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d errors", cur_test, test_errs);
			n_failed++;
		end
		test_errs = 0;
	endtask

	function automatic string word_to_string(logic [255:0] w);
		string s;
		s = "";
		for (int i = 31; i >= 0; i--)
			if (w[i*8 +: 8] != 8'd0)
				s = $sformatf("%s%c", s, w[i*8 +: 8]);
		return s;
	endfunction

	// ----------------------------------------
	// vector file reader
	// ----------------------------------------
	task automatic load_vectors();
		integer        fd;
		integer        code;
		logic [255:0]  tok;
		logic [255:0]  word;
		logic [1023:0] line;
		logic [31:0]   a0;
		logic [31:0]   a1;
		logic [31:0]   a2;
		fd = $fopen("test/c16_loader_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open test/c16_loader_vectors.txt");
			n_errors++;
		end else begin
			while (!$feof(fd)) begin
				tok = '0;
				word = '0;
				a0 = '0;
				a1 = '0;
				a2 = '0;
				code = $fscanf(fd, "%s", tok);
				if (code == 1 && tok[7:0] == "#") begin
					code = $fgets(line, fd);
				end else if (code == 1) begin
					case (tok[7:0])
						"T": code = $fscanf(fd, "%s", word);
						"D": code = $fscanf(fd, "%h", a0);
						"B", "X", "W": code = $fscanf(fd, "%h %h", a0, a1);
						"R": code = $fscanf(fd, "%h %h %h", a0, a1, a2);
						"E": code = 0;
						default: begin
							$display("unknown command in the vector file");
							n_errors++;
						end
					endcase
					cmd_q.push_back(tok[7:0]);
					f0_q.push_back(a0);
					f1_q.push_back(a1);
					f2_q.push_back(a2);
					name_q.push_back(word_to_string(word));
				end
			end
			$fclose(fd);
		end
		n_vec = cmd_q.size();
	endtask

	// ----------------------------------------
	// command player
	// ----------------------------------------
	task automatic run_vectors();
		for (int i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"T": begin
					if (cur_test.len() > 0)
						finish_test();
					cur_test = name_q[i];
				end
				"D": begin
					tick();
					dl_active_i = 1'b1;
					dl_index_i = f0_q[i][7:0];
					// rom images and programs hold the cpu off
					wait_exp = (f0_q[i][7:0] == 8'h00) || (f0_q[i][7:0] == 8'h01)
						|| (f0_q[i][7:0] == 8'h03);
					@(negedge clk28);
					check_value("cpu_wait at start", {31'd0, wait_exp}, {31'd0, cpu_wait_o});
				end
				"B": begin
					tick();
					dl_wr_i = 1'b1;
					dl_addr_i = f0_q[i][24:0];
					dl_data_i = f1_q[i][7:0];
					tick();
					dl_wr_i = 1'b0;
					@(negedge clk28);
					check_value("cpu_wait", {31'd0, wait_exp}, {31'd0, cpu_wait_o});
					idle_cycles(39);
				end
				"E": begin
					tick();
					dl_active_i = 1'b0;
					wait_exp = 1'b0;
					@(negedge clk28);
					check_value("cpu_wait at end", 32'd0, {31'd0, cpu_wait_o});
					// shadow pointers settle two cycles later
					idle_cycles(4);
				end
				"X": begin
					if (wr_addr_q.size() == 0) begin
						$display("test %s: ram write to %h never happened", cur_test, f0_q[i]);
						n_errors++;
						test_errs++;
					end else begin
						check_value("write address", f0_q[i], {7'd0, wr_addr_q.pop_front()});
						check_value("write data", f1_q[i], {24'd0, wr_data_q.pop_front()});
					end
				end
				"W": begin
					tick();
					cpu_addr_i = f0_q[i][15:0];
					cpu_data_i = f1_q[i][7:0];
					cpu_wr_i = 1'b1;
					tick();
					cpu_wr_i = 1'b0;
				end
				"R": begin
					tick();
					cpu_addr_i = f0_q[i][15:0];
					@(negedge clk28);
					check_value("zp hit", {31'd0, f1_q[i][0]}, {31'd0, zp_hit_o});
					check_value("zp data", f2_q[i], {24'd0, zp_data_o});
				end
				default: ;
			endcase
		end
	endtask

	initial begin
		reset = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i = '0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		cpu_addr_i = '0;
		cpu_wr_i = 1'b0;
		cpu_data_i = '0;
		load_vectors();
		repeat (2) @(posedge clk28);
		#1;
		reset = 1'b0;

		// idle outputs and cleared shadow bytes after reset
		cur_test = "reset_state";
		@(negedge clk28);
		check_value("mem_wr", 32'd0, {31'd0, mem_wr_o});
		check_value("cpu_wait", 32'd0, {31'd0, cpu_wait_o});
		check_value("zp hit", 32'd0, {31'd0, zp_hit_o});
		tick();
		cpu_addr_i = 16'h002d;
		@(negedge clk28);
		check_value("zp data", 32'd0, {24'd0, zp_data_o});

		run_vectors();
		if (cur_test.len() > 0)
			finish_test();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0 && n_failed == 0 && n_tests > 1)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== test/c16_loader_vectors.txt ====
# cmd fields in hex: T name | D index | B offset data | E | X addr data | W addr data
# R addr hit data; each B idles 40 cycles, X lines match ram writes in order
T prg_load
D 01
B 0 01
B 1 10
B 2 a1
B 3 b2
B 4 c3
E
X 1001 a1
X 1002 b2
X 1003 c3
T zp_pointers
R 2d 1 05
R 2e 1 10
R 2f 1 05
R 30 1 10
R 31 1 05
R 32 1 10
R 9d 1 05
R 9e 1 10
T zp_cpu_write
W 2e 5a
R 2e 1 5a
R 40 0 ff
T tap_load
D 41
B 0 11
B 1 22
B 2 33
E
X 20000 11
X 20001 22
X 20002 33
T rom_kernal
D 03
B 0 31
B 1 32
E
X 10000 31
X 10001 32
T rom_full
D 00
B 0 aa
B 3fff bb
B 4000 cc
B 4001 dd
E
X 10000 cc
X 10001 dd
